// File: sim.f
src/bridge_pkg.sv
src/ahb_front.sv
src/apb_addr_decode.sv
src/apb_master_fsm.sv
src/apb_slave_mux.sv
src/ahb2apb_bridge.sv
verif/tb_apb_slaves.sv
verif/tb_ahb2apb.sv

// File: src/ahb2apb_bridge.sv
// --------------------------------------------------
// AHB-Lite to APB bridge, top level
// One AHB slave port onto four APB slaves in fixed
// 4 KB windows; write data passes straight through
// --------------------------------------------------
`default_nettype none

module ahb2apb_bridge (
  input  logic                                hclk18,
  input  logic                                hreset_n18,
  // AHB side
  input  logic                                hsel,
  input  logic [bridge_pkg::addr_w-1:0]       haddr,
  input  logic [1:0]                          htrans,
  input  logic                                hwrite,
  input  logic [bridge_pkg::data_w-1:0]       hwdata,
  output logic                                hready,
  output logic [bridge_pkg::data_w-1:0]       hrdata,
  // APB side
  input  logic [bridge_pkg::num_slaves-1:0]   pready,
  input  logic [bridge_pkg::prdata_bus_w-1:0] prdata,
  output logic [bridge_pkg::addr_w-1:0]       paddr,
  output logic                                pwrite,
  output logic [bridge_pkg::data_w-1:0]       pwdata,
  output logic                                penable,
  output logic [bridge_pkg::num_slaves-1:0]   psel
);

  import bridge_pkg::*;

  logic                  accept;
  logic                  data_phase;
  logic [addr_w-1:0]     haddr_q;
  logic                  hwrite_q;
  logic [num_slaves-1:0] slave_sel;
  logic                  miss;
  logic [num_slaves-1:0] psel_vec;
  logic                  pready_sel;
  logic [data_w-1:0]     prdata_sel;
  logic                  done;
  logic                  rdata_valid;

  // AHB data phase lines up with the APB transfer
  assign pwdata = hwdata;

  ahb_front ahb_front_i (
    .hclk18      (hclk18),
    .hreset_n18  (hreset_n18),
    .hsel        (hsel),
    .haddr       (haddr),
    .htrans      (htrans),
    .hwrite      (hwrite),
    .done        (done),
    .rdata_valid (rdata_valid),
    .prdata_sel  (prdata_sel),
    .hready      (hready),
    .hrdata      (hrdata),
    .accept      (accept),
    .data_phase  (data_phase),
    .haddr_q     (haddr_q),
    .hwrite_q    (hwrite_q)
  );

  apb_addr_decode apb_addr_decode_i (
    .hclk18     (hclk18),
    .hreset_n18 (hreset_n18),
    .accept     (accept),
    .haddr      (haddr),
    .slave_sel  (slave_sel),
    .miss       (miss)
  );

  apb_master_fsm apb_master_fsm_i (
    .hclk18      (hclk18),
    .hreset_n18  (hreset_n18),
    .data_phase  (data_phase),
    .haddr_q     (haddr_q),
    .hwrite_q    (hwrite_q),
    .slave_sel   (slave_sel),
    .miss        (miss),
    .pready_sel  (pready_sel),
    .paddr       (paddr),
    .pwrite      (pwrite),
    .penable     (penable),
    .psel_vec    (psel_vec),
    .done        (done),
    .rdata_valid (rdata_valid)
  );

  apb_slave_mux apb_slave_mux_i (
    .psel_vec   (psel_vec),
    .pready     (pready),
    .prdata     (prdata),
    .psel       (psel),
    .pready_sel (pready_sel),
    .prdata_sel (prdata_sel)
  );

endmodule

`default_nettype wire

// File: src/ahb_front.sv
// --------------------------------------------------
// AHB-Lite slave front end
// Takes NONSEQ/SEQ address phases, holds the address
// and direction, stretches the data phase with hready
// and returns read data when the APB side completes
// --------------------------------------------------
`default_nettype none

module ahb_front (
  input  logic                          hclk18,
  input  logic                          hreset_n18,
  input  logic                          hsel,
  input  logic [bridge_pkg::addr_w-1:0] haddr,
  input  logic [1:0]                    htrans,
  input  logic                          hwrite,
  input  logic                          done,
  input  logic                          rdata_valid,
  input  logic [bridge_pkg::data_w-1:0] prdata_sel,
  output logic                          hready,
  output logic [bridge_pkg::data_w-1:0] hrdata,
  output logic                          accept,
  output logic                          data_phase,
  output logic [bridge_pkg::addr_w-1:0] haddr_q,
  output logic                          hwrite_q
);

  import bridge_pkg::*;

  logic trans_valid;

  // Only NONSEQ and SEQ start a transfer, IDLE and BUSY are ignored
  assign trans_valid = hsel && ((htrans == htrans_nonseq) || (htrans == htrans_seq));

  // Address phase is taken only while the previous one has finished
  assign accept = trans_valid && hready;

  // --------------------------------------------------
  // Phase tracking and read data
  // --------------------------------------------------
  always_ff @(posedge hclk18 or negedge hreset_n18) begin
    if (!hreset_n18) begin
      hready     <= 1'b1;
      data_phase <= 1'b0;
      hrdata     <= '0;
    end else if (accept) begin
      hready     <= 1'b0;
      data_phase <= 1'b1;
    end else if (done) begin
      hready     <= 1'b1;
      data_phase <= 1'b0;
      // Unmapped reads complete with zero data
      if (!hwrite_q) begin
        hrdata <= rdata_valid ? prdata_sel : '0;
      end
    end
  end

  // Address and direction held for the whole data phase
  always_ff @(posedge hclk18) begin
    if (accept) begin
      haddr_q  <= haddr;
      hwrite_q <= hwrite;
    end
  end

  // --------------------------------------------------
  // Checks
  // --------------------------------------------------

  // The bus stays stalled for the whole data phase
  a_no_ready_in_data_phase : assert property (
    @(posedge hclk18) disable iff (!hreset_n18)
    !(hready && data_phase)
  );

  // No second transfer while one is in flight
  a_no_accept_in_data_phase : assert property (
    @(posedge hclk18) disable iff (!hreset_n18)
    accept |-> !data_phase
  );

  // Completion only ever closes an open data phase
  a_done_in_data_phase : assert property (
    @(posedge hclk18) disable iff (!hreset_n18)
    done |-> data_phase ##1 (hready && !data_phase)
  );

endmodule

`default_nettype wire

// File: src/apb_addr_decode.sv
// --------------------------------------------------
// APB address decoder
// Maps the AHB address onto one of four 4 KB windows
// and registers a one-hot select, or a miss flag for
// an address outside every window
// --------------------------------------------------
`default_nettype none

module apb_addr_decode (
  input  logic                              hclk18,
  input  logic                              hreset_n18,
  input  logic                              accept,
  input  logic [bridge_pkg::addr_w-1:0]     haddr,
  output logic [bridge_pkg::num_slaves-1:0] slave_sel,
  output logic                              miss
);

  import bridge_pkg::*;

  ahb_addr_u               addr_view;
  logic                    hit;
  logic [num_slaves-1:0]   sel_next;

  assign addr_view.raw = haddr;

  // Tag must match the bridge base and the spare bits must be clear
  assign hit = (addr_view.fields.tag == bridge_base_tag) &&
               (addr_view.fields.unused == '0);

  always_comb begin
    sel_next = '0;
    if (hit) begin
      sel_next[addr_view.fields.slave_idx] = 1'b1;
    end
  end

  // Decode result follows the address phase by one cycle
  always_ff @(posedge hclk18 or negedge hreset_n18) begin
    if (!hreset_n18) begin
      slave_sel <= '0;
      miss      <= 1'b0;
    end else if (accept) begin
      slave_sel <= sel_next;
      miss      <= !hit;
    end
  end

  // --------------------------------------------------
  // Checks
  // --------------------------------------------------
  a_sel_onehot : assert property (
    @(posedge hclk18) disable iff (!hreset_n18)
    $onehot0(slave_sel) && !((|slave_sel) && miss)
  );

endmodule

`default_nettype wire

// File: src/apb_master_fsm.sv
// --------------------------------------------------
// APB master state machine
// Runs one SETUP/ACCESS transfer per AHB data phase,
// waits on pready and signals completion back to the
// AHB side; unmapped addresses finish from IDLE
// --------------------------------------------------
`default_nettype none

module apb_master_fsm (
  input  logic                              hclk18,
  input  logic                              hreset_n18,
  input  logic                              data_phase,
  input  logic [bridge_pkg::addr_w-1:0]     haddr_q,
  input  logic                              hwrite_q,
  input  logic [bridge_pkg::num_slaves-1:0] slave_sel,
  input  logic                              miss,
  input  logic                              pready_sel,
  output logic [bridge_pkg::addr_w-1:0]     paddr,
  output logic                              pwrite,
  output logic                              penable,
  output logic [bridge_pkg::num_slaves-1:0] psel_vec,
  output logic                              done,
  output logic                              rdata_valid
);

  import bridge_pkg::*;

  logic [2:0] state;
  logic       in_idle;
  logic       in_access;
  logic       start_hit;
  logic       end_miss;
  logic       end_access;

  assign in_idle   = (state == apb_state_idle);
  assign in_access = (state == apb_state_access);

  // Decode result is valid in the cycle after accept
  assign start_hit  = in_idle && data_phase && !miss;
  assign end_miss   = in_idle && data_phase && miss;
  assign end_access = in_access && pready_sel;

  assign done        = end_miss || end_access;
  assign rdata_valid = end_access;

  // --------------------------------------------------
  // IDLE -> SETUP -> ACCESS -> IDLE
  // --------------------------------------------------
  always_ff @(posedge hclk18 or negedge hreset_n18) begin
    if (!hreset_n18) begin
      state    <= apb_state_idle;
      psel_vec <= '0;
      penable  <= 1'b0;
      paddr    <= '0;
      pwrite   <= 1'b0;
    end else begin
      case (state)
        apb_state_idle: begin
          if (start_hit) begin
            state    <= apb_state_setup;
            psel_vec <= slave_sel;
            paddr    <= haddr_q;
            pwrite   <= hwrite_q;
          end
        end

        apb_state_setup: begin
          state   <= apb_state_access;
          penable <= 1'b1;
        end

        // Wait states hold everything until the slave is ready
        apb_state_access: begin
          if (pready_sel) begin
            state    <= apb_state_idle;
            penable  <= 1'b0;
            psel_vec <= '0;
          end
        end

        default: begin
          state    <= apb_state_idle;
          penable  <= 1'b0;
          psel_vec <= '0;
        end
      endcase
    end
  end

  // --------------------------------------------------
  // Checks
  // --------------------------------------------------
  a_enable_has_select : assert property (
    @(posedge hclk18) disable iff (!hreset_n18)
    penable |-> (|psel_vec)
  );

  // Address is held through every wait state
  a_paddr_stable : assert property (
    @(posedge hclk18) disable iff (!hreset_n18)
    (in_access && !pready_sel) |=> $stable(paddr) && $stable(pwrite)
  );

endmodule

`default_nettype wire

// File: src/apb_slave_mux.sv
// --------------------------------------------------
// APB slave fan-out and read merge
// Drives the psel lines and picks pready and prdata
// of the selected slave by AND-OR masking
// --------------------------------------------------
`default_nettype none

module apb_slave_mux (
  input  logic [bridge_pkg::num_slaves-1:0]   psel_vec,
  input  logic [bridge_pkg::num_slaves-1:0]   pready,
  input  logic [bridge_pkg::prdata_bus_w-1:0] prdata,
  output logic [bridge_pkg::num_slaves-1:0]   psel,
  output logic                                pready_sel,
  output logic [bridge_pkg::data_w-1:0]       prdata_sel
);

  import bridge_pkg::*;

  assign psel = psel_vec;

  // Unselected slaves cannot complete a transfer
  assign pready_sel = |(psel_vec & pready);

  // Slave i occupies bits [i*data_w +: data_w] of the flat bus
  always_comb begin
    prdata_sel = '0;
    for (int i = 0; i < num_slaves; i++) begin
      prdata_sel = prdata_sel | (prdata[i*data_w +: data_w] & {data_w{psel_vec[i]}});
    end
  end

endmodule

`default_nettype wire

// File: src/bridge_pkg.sv
// --------------------------------------------------
// AHB-Lite to APB bridge shared definitions
// Bus widths, the four-window address map, APB
// state codes and the decoded address view
// --------------------------------------------------
`default_nettype none

package bridge_pkg;

  // Bus widths
  localparam int unsigned addr_w       = 32;
  localparam int unsigned data_w       = 32;
  localparam int unsigned num_slaves   = 4;
  localparam int unsigned slave_idx_w  = 2;
  localparam int unsigned win_offset_w = 12;
  localparam int unsigned prdata_bus_w = num_slaves * data_w;

  // Bits between the slave index and the tag, zero for a hit
  localparam int unsigned unused_w = 2;
  localparam int unsigned tag_w    = addr_w - unused_w - slave_idx_w - win_offset_w;

  // Windows start at 32'h0001_0000, one 4 KB window per slave
  localparam logic [tag_w-1:0] bridge_base_tag = 'h0001;

  // Accepted htrans codes
  localparam logic [1:0] htrans_nonseq = 2'b10;
  localparam logic [1:0] htrans_seq    = 2'b11;

  // One-hot APB state codes
  localparam logic [2:0] apb_state_idle   = 3'b001;
  localparam logic [2:0] apb_state_setup  = 3'b010;
  localparam logic [2:0] apb_state_access = 3'b100;

  // Two views of one AHB byte address
  typedef union packed {
    logic [addr_w-1:0] raw;
    struct packed {
      logic [tag_w-1:0]        tag;
      logic [unused_w-1:0]     unused;
      logic [slave_idx_w-1:0]  slave_idx;
      logic [win_offset_w-1:0] offset;
    } fields;
  } ahb_addr_u;

endpackage

`default_nettype wire

// File: verif/tb_ahb2apb.sv
// --------------------------------------------------
// AHB-Lite to APB bridge testbench
// Random AHB transfers from an LCG, checked against a
// memory model of the four APB windows
// --------------------------------------------------
`default_nettype none

module tb_ahb2apb;

  import bridge_pkg::*;

  localparam int unsigned clk_period    = 4;
  localparam int unsigned reset_cycles  = 8;
  localparam int unsigned max_transfers = 400;
  localparam int unsigned timeout = (max_transfers * 10 + reset_cycles) * clk_period;
  localparam logic [31:0] win_base = 32'h0001_0000;

  logic                    hclk18, hreset_n18;
  logic                    hsel, hwrite, hready, pwrite, penable;
  logic [1:0]              htrans;
  logic [31:0]             haddr, hwdata, hrdata, paddr, pwdata;
  logic [num_slaves-1:0]   psel, pready;
  logic [prdata_bus_w-1:0] prdata;
  logic [31:0]             rng_state;
  logic [31:0]             model_mem [0:4095];

  ahb2apb_bridge ahb2apb_bridge_i (
    .hclk18(hclk18), .hreset_n18(hreset_n18), .hsel(hsel), .haddr(haddr),
    .htrans(htrans), .hwrite(hwrite), .hwdata(hwdata), .hready(hready),
    .hrdata(hrdata), .pready(pready), .prdata(prdata), .paddr(paddr),
    .pwrite(pwrite), .pwdata(pwdata), .penable(penable), .psel(psel)
  );

  tb_apb_slaves slaves_i (
    .hclk18(hclk18), .hreset_n18(hreset_n18), .psel(psel), .penable(penable),
    .pwrite(pwrite), .paddr(paddr), .pwdata(pwdata), .pready(pready), .prdata(prdata)
  );

  initial begin
    hclk18 = 1'b0;
    forever #(clk_period / 2) hclk18 = ~hclk18;
  end

  function automatic logic [31:0] next_rand();
    rng_state = rng_state * 32'h0019_660d + 32'h3c6e_f35f;
    return rng_state;
  endfunction

  // Four 4 KB windows from win_base, nothing else is mapped
  function automatic logic in_window(input logic [31:0] addr);
    return (addr >= win_base) && (addr < win_base + 32'h4000);
  endfunction

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected) begin
      $display("[ERROR] %s expected 0x%08h actual 0x%08h", name, expected, actual);
      $display("*** TEST FAILED ***");
      $fatal(1, "value mismatch on %s", name);
    end
  endtask

  // Idle cycles, either hsel low or htrans IDLE on a mapped address
  task automatic run_idle(input int cycles);
    logic [31:0] r;
    for (int c = 0; c < cycles; c++) begin
      r = next_rand();
      @(posedge hclk18);
      hsel   <= r[20];
      htrans <= r[20] ? 2'b00 : htrans_nonseq;
      haddr  <= win_base + {18'h0, r[29:28], r[31:22], 2'b00};
      hwrite <= r[21];
      @(negedge hclk18);
      check_value("hready", 32'd1, hready);
      check_value("psel", 32'd0, psel);
      check_value("penable", 32'd0, penable);
    end
  endtask

  task automatic run_transfer(input logic wr, input logic [31:0] addr,
                              input logic [31:0] wdata, input logic use_seq);
    logic        exp_hit;
    int          idx;
    int          k;
    int          low_cycles;
    int          waits;
    logic [3:0]  exp_psel;
    logic [31:0] exp_rdata;
    exp_hit    = in_window(addr);
    idx        = (addr - win_base) >> 12;
    exp_psel   = exp_hit ? (4'b0001 << idx) : 4'b0000;
    k          = 0;
    low_cycles = 0;
    waits      = 0;
    @(posedge hclk18);
    hsel   <= 1'b1;
    haddr  <= addr;
    htrans <= use_seq ? htrans_seq : htrans_nonseq;
    hwrite <= wr;
    // Accept edge, data phase starts
    @(posedge hclk18);
    hsel   <= 1'b0;
    htrans <= 2'b00;
    hwdata <= wdata;
    do begin
      @(negedge hclk18);
      k++;
      if (!hready) begin
        low_cycles++;
        check_value("psel", (exp_hit && k >= 2) ? exp_psel : 4'b0000, psel);
        check_value("penable", (exp_hit && k >= 3) ? 32'd1 : 32'd0, penable);
        if (exp_hit && k >= 2) begin
          check_value("paddr", addr, paddr);
          check_value("pwrite", wr, pwrite);
          if (wr) check_value("pwdata", wdata, pwdata);
        end
        if (exp_hit && k >= 3 && !pready[idx]) waits++;
      end
    end while (!hready);
    check_value("psel", 32'd0, psel);
    check_value("penable", 32'd0, penable);
    check_value("hready_low_cycles", exp_hit ? 3 + waits : 1, low_cycles);
    if (wr && exp_hit) model_mem[idx*1024 + addr[11:2]] = wdata;
    if (!wr) begin
      exp_rdata = exp_hit ? model_mem[idx*1024 + addr[11:2]] : 32'h0;
      check_value("hrdata", exp_rdata, hrdata);
    end
  endtask

  initial begin
    logic [31:0] addrs [0:15];
    logic [31:0] r;
    logic [31:0] addr;
    hreset_n18 = 1'b0;
    hsel       = 1'b0;
    haddr      = '0;
    htrans     = 2'b00;
    hwrite     = 1'b0;
    hwdata     = '0;
    rng_state  = 32'h2d95cd15;
    for (int j = 0; j < 4096; j++) model_mem[j] = (j * 32'h9e37_79b1) ^ 32'h5a5a_c3c3;
    repeat (reset_cycles) @(posedge hclk18);
    hreset_n18 <= 1'b1;
    @(negedge hclk18);
    check_value("hready", 32'd1, hready);
    check_value("psel", 32'd0, psel);
    check_value("penable", 32'd0, penable);
    check_value("hrdata", 32'd0, hrdata);

    // Write then read back random words of every window
    for (int s = 0; s < 4; s++) begin
      for (int w = 0; w < 16; w++) begin
        r        = next_rand();
        addrs[w] = win_base + {18'h0, s[1:0], r[31:22], 2'b00};
        run_transfer(1'b1, addrs[w], next_rand(), w[0]);
      end
      for (int w = 0; w < 16; w++) run_transfer(1'b0, addrs[w], 32'h0, w[1]);
    end

    // Mixed traffic with gaps and unmapped addresses
    for (int n = 0; n < 240; n++) begin
      r = next_rand();
      run_idle(r[17:16] % 3);
      r = next_rand();
      if (r[18:16] != 3'd0) begin
        addr = win_base + {18'h0, r[21:20], r[31:22], 2'b00};
      end else if (r[27]) begin
        addr = 32'h0001_4000 | {16'h0, r[25], 3'h0, r[31:22], 2'b00};
      end else begin
        addr = 32'h0002_0000 + {14'h0, r[31:16], 2'b00};
      end
      run_transfer(r[23], addr, next_rand(), r[24]);
    end

    $display("*** TEST PASSED ***");
    $finish;
  end

  initial begin
    #(timeout);
    $display("Watchdog expired before all transfers completed");
    $display("*** TEST FAILED ***");
    $fatal(1, "timeout");
  end

endmodule

`default_nettype wire

// File: verif/tb_apb_slaves.sv
// --------------------------------------------------
// Four behavioral APB slaves for the bridge testbench
// 1024 words each, with 0 to 3 random wait states
// per transfer
// --------------------------------------------------
`default_nettype none

module tb_apb_slaves (
  input  logic         hclk18,
  input  logic         hreset_n18,
  input  logic [3:0]   psel,
  input  logic         penable,
  input  logic         pwrite,
  input  logic [31:0]  paddr,
  input  logic [31:0]  pwdata,
  output logic [3:0]   pready,
  output logic [127:0] prdata
);

  logic [31:0] mem [0:4095];
  logic [1:0]  wait_cnt [0:3];
  logic [31:0] lcg_state;

  function automatic logic [31:0] step_lcg(input logic [31:0] s);
    return s * 32'h0019_660d + 32'h3c6e_f35f;
  endfunction

  // Slave i owns words i*1024 .. i*1024+1023
  initial begin
    for (int a = 0; a < 4096; a++) begin
      mem[a] = (a * 32'h9e37_79b1) ^ 32'h5a5a_c3c3;
    end
  end

  always_comb begin
    for (int i = 0; i < 4; i++) begin
      pready[i]          = (wait_cnt[i] == 2'd0);
      prdata[i*32 +: 32] = mem[i*1024 + paddr[11:2]];
    end
  end

  // Wait count drawn in SETUP, counted down in ACCESS
  always_ff @(posedge hclk18 or negedge hreset_n18) begin
    if (!hreset_n18) begin
      lcg_state <= 32'h2d95cd15;
      for (int i = 0; i < 4; i++) begin
        wait_cnt[i] <= 2'd0;
      end
    end else begin
      for (int i = 0; i < 4; i++) begin
        if (psel[i] && !penable) begin
          wait_cnt[i] <= lcg_state[17:16];
          lcg_state   <= step_lcg(lcg_state);
        end else if (psel[i] && penable && (wait_cnt[i] != 2'd0)) begin
          wait_cnt[i] <= wait_cnt[i] - 2'd1;
        end
      end
    end
  end

  always @(posedge hclk18) begin
    for (int i = 0; i < 4; i++) begin
      if (psel[i] && penable && pready[i] && pwrite) begin
        mem[i*1024 + paddr[11:2]] <= pwdata;
      end
    end
  end

endmodule

`default_nettype wire
